// File: src.f
rtl/wresp_bank_pkg.sv
rtl/slot_allocator.sv
rtl/next_ptr_table.sv
rtl/id_queue_ctrl.sv
rtl/release_arbiter.sv
rtl/msg_ram.sv
rtl/wresp_bank.sv
verification/wresp_bank_asserts.sv
verification/wresp_bank_tb.sv

// File: verification/wresp_bank_tb.sv
// Testbench for the write-response bank with random reservations, fills and gated releases
`timescale 1ns/100ps

module wresp_bank_tb import wresp_bank_pkg::*; ();

  localparam int unsigned NumCycles   = 600;
  localparam int unsigned QuietStart  = 450;
  localparam int unsigned DrainStart  = 500;
  localparam int unsigned ResetCycles = 4;
  localparam time         TimeoutNs   = (ResetCycles + NumCycles + 100) * 20;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic i_res_valid, o_res_ready, i_in_valid, o_in_ready;
  logic o_out_valid, i_out_ready;
  logic [NumIds-1:0] i_res_id_onehot;
  logic [Capacity-1:0] i_release_en, o_released_onehot;
  addr_t o_res_addr;
  wresp_t i_in_data, o_out_data;

  // Reference queues per identifier, slots in reservation order and contents in fill order
  addr_t addr_q [NumIds][$];
  logic [MsgWidth-1:0] data_q [NumIds][$];
  // Reservations not yet matched by an input
  int pend [NumIds];
  logic [Capacity-1:0] held, filled, en_seen;
  int held_cnt, err_cnt, quiet_cnt;
  logic [15:0] lfsr_q = 16'd44;
  id_t res_id;

  always #10 clk_i = ~clk_i;

  wresp_bank #(.NumIds(NumIds), .Capacity(Capacity)) dut_i (.*);

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] draw_bits(input int unsigned n);
    logic [15:0] bits;
    bits = '0;
    for (int unsigned k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      bits = {bits[14:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  task automatic flag_error(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////

  // Random traffic, then a phase with release disabled, then a full drain
  task automatic drive_cycle(input int unsigned cyc);
    i_res_valid = 1'(draw_bits(1));
    res_id = id_t'(draw_bits(2));
    i_res_id_onehot = NumIds'(1) << res_id;
    i_in_valid = 1'(draw_bits(1));
    i_in_data.id = id_t'(draw_bits(2));
    i_in_data.content = draw_bits(16);
    if (cyc >= DrainStart) begin
      i_release_en = '1;
      i_out_ready = 1'b1;
      quiet_cnt = 0;
    end else if (cyc >= QuietStart) begin
      i_release_en = '0;
      i_out_ready = 1'b1;
      quiet_cnt++;
    end else begin
      i_release_en = Capacity'(draw_bits(Capacity));
      i_out_ready = (draw_bits(2) != '0);
      quiet_cnt = 0;
    end
  endtask

  // Runs mid-cycle where inputs and outputs are settled, then books this cycle's handshakes
  task automatic check_cycle();
    id_t oid, iid;
    addr_t exp_addr, fill_slot;
    oid = o_out_data.id;
    iid = i_in_data.id;
    exp_addr = '0;
    assert (o_res_ready == (held_cnt != Capacity))
      else flag_error("o_res_ready disagrees with the held slot count");
    assert (!o_res_ready || !held[o_res_addr])
      else flag_error("o_res_addr names a slot that is still held");
    assert (o_in_ready == (i_in_valid && pend[iid] != 0))
      else flag_error("o_in_ready disagrees with open reservations");
    assert (quiet_cnt < 2 || !o_out_valid)
      else flag_error("new output while release enable is zero");
    if (o_out_valid && data_q[oid].size() == 0) begin
      $display("Output at %0t carries identifier %0d with no filled entry", $time, oid);
      err_cnt++;
    end else if (o_out_valid) begin
      exp_addr = addr_q[oid][0];
      assert (en_seen[exp_addr])
        else flag_error("output without release enable after its input");
      assert (o_out_data.content == data_q[oid][0])
        else flag_error("output content differs from the oldest entry of its identifier");
    end
    // Enables only count once the slot holds data
    en_seen = en_seen | (filled & i_release_en);
    if (o_out_valid && i_out_ready && data_q[oid].size() != 0) begin
      assert (o_released_onehot == (Capacity'(1) << exp_addr))
        else flag_error("o_released_onehot does not mark the reserved slot");
      exp_addr = addr_q[oid].pop_front();
      void'(data_q[oid].pop_front());
      held[exp_addr] = 1'b0;
      filled[exp_addr] = 1'b0;
      en_seen[exp_addr] = 1'b0;
      held_cnt--;
    end
    // Oldest unfilled slot of the identifier takes the input
    if (i_in_valid && o_in_ready && addr_q[iid].size() > data_q[iid].size()) begin
      fill_slot = addr_q[iid][data_q[iid].size()];
      data_q[iid].push_back(i_in_data.content);
      filled[fill_slot] = 1'b1;
      pend[iid]--;
    end
    if (i_res_valid && o_res_ready) begin
      addr_q[res_id].push_back(o_res_addr);
      held[o_res_addr] = 1'b1;
      held_cnt++;
      pend[res_id]++;
    end
  endtask

  initial begin
    rst_ni = 1'b0;
    i_res_valid = 1'b0;
    i_res_id_onehot = '0;
    i_in_valid = 1'b0;
    i_in_data = '0;
    i_out_ready = 1'b0;
    i_release_en = '0;
    held = '0;
    filled = '0;
    en_seen = '0;
    pend = '{default: 0};
    held_cnt = 0;
    err_cnt = 0;
    quiet_cnt = 0;
    res_id = '0;
    repeat (ResetCycles) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    for (int unsigned cyc = 0; cyc < NumCycles; cyc++) begin
      drive_cycle(cyc);
      @(negedge clk_i);
      check_cycle();
      @(posedge clk_i);
      #2;
    end
    $display("Errors: %0d testbench checks, %0d assertions", err_cnt,
             dut_i.asserts_i.fail_cnt);
    if (err_cnt == 0 && dut_i.asserts_i.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not reach its end in time");
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: verification/wresp_bank_asserts.sv
// Bound checker for the write-response bank output handshake and release rules
`timescale 1ns/100ps

module wresp_bank_asserts import wresp_bank_pkg::*; #(
  parameter int unsigned Capacity = wresp_bank_pkg::Capacity
) (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                o_out_valid,
  input logic                i_out_ready,
  input wresp_t              o_out_data,
  input logic [Capacity-1:0] o_released_onehot
);

  // Count of failed assertions
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////

  // Held word stays put while the sink stalls
  hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data))
    else begin
      fail_cnt++;
      $error("Output word changed while stalled");
    end

  // Exactly one slot freed per accepted output
  onehot_on_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    o_out_valid && i_out_ready |-> $onehot(o_released_onehot))
    else begin
      fail_cnt++;
      $error("Released address is not one-hot on accept");
    end

  // No slot freed without a handshake
  quiet_without_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(o_out_valid && i_out_ready) |-> o_released_onehot == '0)
    else begin
      fail_cnt++;
      $error("Released address set without an accepted output");
    end

endmodule

bind wresp_bank wresp_bank_asserts #(.Capacity(Capacity)) asserts_i (
  .clk_i(clk_i),
  .rst_ni(rst_ni),
  .o_out_valid(o_out_valid),
  .i_out_ready(i_out_ready),
  .o_out_data(o_out_data),
  .o_released_onehot(o_released_onehot)
);

// File: rtl/wresp_bank.sv
// Write-response bank with per-identifier linked-list queues over shared slots
`timescale 1ns/100ps

module wresp_bank import wresp_bank_pkg::*; #(
  parameter int unsigned NumIds   = wresp_bank_pkg::NumIds,
  parameter int unsigned Capacity = wresp_bank_pkg::Capacity
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Reservation
  input  logic                i_res_valid,
  output logic                o_res_ready,
  input  logic [NumIds-1:0]   i_res_id_onehot,
  output addr_t               o_res_addr,
  // Input responses
  input  logic                i_in_valid,
  output logic                o_in_ready,
  input  wresp_t              i_in_data,
  // Output responses
  output logic                o_out_valid,
  input  logic                i_out_ready,
  output wresp_t              o_out_data,
  // Release
  input  logic [Capacity-1:0] i_release_en,
  output logic [Capacity-1:0] o_released_onehot
);

  logic res_fire, any_free, free_valid, link_we;
  addr_t free_addr, wr_addr, link_addr, link_next;
  addr_t fill_addr, fill_next, tail_rd_addr, tail_next, rel_addr;
  addr_t [NumIds-1:0] tail_addr;
  logic  [NumIds-1:0] has_filled;
  slot_req_t sel;
  id_t sel_id, out_id;
  logic [MsgWidth-1:0] rd_data;

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  assign o_res_ready = any_free;
  assign o_res_addr  = free_addr;
  assign res_fire    = i_res_valid && o_res_ready;

  // Output word is the held identifier with the RAM word
  assign o_out_data.id      = out_id;
  assign o_out_data.content = rd_data;

  slot_allocator #(.Capacity(Capacity)) slot_alloc_i (
    .clk_i, .rst_ni,
    .i_alloc(res_fire), .i_free_valid(free_valid), .i_free_addr(rel_addr),
    .o_free_addr(free_addr), .o_any_free(any_free), .o_released_onehot
  );

  next_ptr_table #(.Capacity(Capacity)) next_ptr_i (
    .clk_i, .rst_ni,
    .i_wr_en(link_we), .i_wr_addr(link_addr), .i_wr_next(link_next),
    .i_rd_a_addr(fill_addr), .o_rd_a_next(fill_next),
    .i_rd_b_addr(tail_rd_addr), .o_rd_b_next(tail_next)
  );

  id_queue_ctrl #(.NumIds(NumIds), .Capacity(Capacity)) queue_ctrl_i (
    .clk_i, .rst_ni,
    .i_res_fire(res_fire), .i_res_id_onehot, .i_res_addr(free_addr),
    .i_in_valid, .i_in_id(i_in_data.id), .o_in_ready, .o_wr_addr(wr_addr),
    .i_sel(sel), .i_sel_id(sel_id),
    .o_tail_addr(tail_addr), .o_has_filled(has_filled),
    .o_link_we(link_we), .o_link_addr(link_addr), .o_link_next(link_next),
    .o_fill_addr(fill_addr), .i_fill_next(fill_next),
    .o_tail_rd_addr(tail_rd_addr), .i_tail_next(tail_next)
  );

  release_arbiter #(.NumIds(NumIds), .Capacity(Capacity)) arbiter_i (
    .clk_i, .rst_ni, .i_release_en,
    .i_tail_addr(tail_addr), .i_has_filled(has_filled),
    .o_sel(sel), .o_sel_id(sel_id),
    .i_out_ready, .o_out_valid, .o_out_id(out_id),
    .o_free_valid(free_valid), .o_free_addr(rel_addr)
  );

  // o_in_ready already includes i_in_valid
  msg_ram #(.Capacity(Capacity)) msg_ram_i (
    .clk_i,
    .i_wr_en(o_in_ready), .i_wr_addr(wr_addr), .i_wr_data(i_in_data.content),
    .i_rd(sel), .o_rd_data(rd_data)
  );

endmodule

// File: rtl/msg_ram.sv
// Message storage with one write port and a registered read port
`timescale 1ns/100ps

module msg_ram import wresp_bank_pkg::*; #(
  parameter int unsigned Capacity = wresp_bank_pkg::Capacity
) (
  input  logic                clk_i,
  input  logic                i_wr_en,
  input  addr_t               i_wr_addr,
  input  logic [MsgWidth-1:0] i_wr_data,
  input  slot_req_t           i_rd,
  output logic [MsgWidth-1:0] o_rd_data
);

  logic [MsgWidth-1:0] mem [Capacity];
  logic [MsgWidth-1:0] rd_data_q;

  // Write port
  always_ff @(posedge clk_i) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Read register only moves on a new request, so held data stays put
  always_ff @(posedge clk_i) begin
    if (i_rd.valid) begin
      rd_data_q <= mem[i_rd.addr];
    end
  end

  assign o_rd_data = rd_data_q;

endmodule

// File: rtl/release_arbiter.sv
// Release arbiter picking the lowest eligible identifier and holding the output stage
`timescale 1ns/100ps

module release_arbiter import wresp_bank_pkg::*; #(
  parameter int unsigned NumIds   = wresp_bank_pkg::NumIds,
  parameter int unsigned Capacity = wresp_bank_pkg::Capacity
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Multi-hot release enable per slot
  input  logic [Capacity-1:0] i_release_en,
  // Queue state
  input  addr_t [NumIds-1:0]  i_tail_addr,
  input  logic  [NumIds-1:0]  i_has_filled,
  // Selection towards the queues and the RAM
  output slot_req_t           o_sel,
  output id_t                 o_sel_id,
  // Output handshake
  input  logic                i_out_ready,
  output logic                o_out_valid,
  output id_t                 o_out_id,
  // Slot to free after acceptance
  output logic                o_free_valid,
  output addr_t               o_free_addr
);

  logic [NumIds-1:0] elig;
  logic              can_load;

  // Output stage contents
  logic  out_valid_q;
  id_t   out_id_q;
  addr_t out_addr_q;

  // Oldest filled entry of the identifier must be enabled for release
  for (genvar g = 0; g < NumIds; g++) begin : gen_elig
    assign elig[g] = i_has_filled[g] && i_release_en[i_tail_addr[g]];
  end

  // Stage is free, or being emptied this cycle
  assign can_load = !out_valid_q || i_out_ready;

  // Lowest identifier wins
  always_comb begin
    o_sel_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (elig[i]) begin
        o_sel_id = id_t'(i);
      end
    end
  end

  assign o_sel.valid = can_load && (|elig);
  assign o_sel.addr  = i_tail_addr[o_sel_id];

  // Held until accepted, RAM data arrives alongside
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      out_id_q    <= '0;
      out_addr_q  <= '0;
    end else if (can_load) begin
      out_valid_q <= o_sel.valid;
      out_id_q    <= o_sel_id;
      out_addr_q  <= o_sel.addr;
    end
  end

  assign o_out_valid  = out_valid_q;
  assign o_out_id     = out_id_q;
  assign o_free_valid = out_valid_q && i_out_ready;
  assign o_free_addr  = out_addr_q;

endmodule

// File: rtl/id_queue_ctrl.sv
// Per-identifier linked-list queue pointers and counters for reservation, fill and release
`timescale 1ns/100ps

module id_queue_ctrl import wresp_bank_pkg::*; #(
  parameter int unsigned NumIds   = wresp_bank_pkg::NumIds,
  parameter int unsigned Capacity = wresp_bank_pkg::Capacity
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Reservation
  input  logic                    i_res_fire,
  input  logic [NumIds-1:0]       i_res_id_onehot,
  input  addr_t                   i_res_addr,
  // Input
  input  logic                    i_in_valid,
  input  id_t                     i_in_id,
  output logic                    o_in_ready,
  output addr_t                   o_wr_addr,
  // Selection from the arbiter
  input  slot_req_t               i_sel,
  input  id_t                     i_sel_id,
  // Queue state for the arbiter
  output addr_t [NumIds-1:0]      o_tail_addr,
  output logic  [NumIds-1:0]      o_has_filled,
  // Link table access
  output logic                    o_link_we,
  output addr_t                   o_link_addr,
  output addr_t                   o_link_next,
  output addr_t                   o_fill_addr,
  input  addr_t                   i_fill_next,
  output addr_t                   o_tail_rd_addr,
  input  addr_t                   i_tail_next
);

  localparam int unsigned CntWidth = $clog2(Capacity + 1);
  typedef logic [CntWidth-1:0] cnt_t;

  // head: newest reserved slot, fill: oldest unfilled slot, tail: oldest filled slot
  addr_t head_d [NumIds], head_q [NumIds];
  addr_t fill_d [NumIds], fill_q [NumIds];
  addr_t tail_d [NumIds], tail_q [NumIds];
  // Reserved but unfilled, and filled but not yet selected
  cnt_t  res_cnt_d [NumIds], res_cnt_q [NumIds];
  cnt_t  fill_cnt_d [NumIds], fill_cnt_q [NumIds];

  logic [NumIds-1:0] res_hit, in_hit, sel_hit;
  logic [NumIds-1:0] f_empty, q_empty;

  ////////////////////////////////////////
  // Per-identifier events
  ////////////////////////////////////////

  for (genvar g = 0; g < NumIds; g++) begin : gen_events
    assign res_hit[g] = i_res_fire && i_res_id_onehot[g];
    assign in_hit[g]  = o_in_ready && (i_in_id == id_t'(g));
    assign sel_hit[g] = i_sel.valid && (i_sel_id == id_t'(g));
    // No filled entry left once this cycle's selection is taken
    assign f_empty[g] = (fill_cnt_q[g] == '0) || ((fill_cnt_q[g] == cnt_t'(1)) && sel_hit[g]);
    assign q_empty[g] = (res_cnt_q[g] == '0) && f_empty[g];
    assign o_tail_addr[g]  = tail_q[g];
    assign o_has_filled[g] = fill_cnt_q[g] != '0;
  end

  // Ready depends on valid, needs an open reservation for that identifier
  assign o_in_ready  = i_in_valid && (res_cnt_q[i_in_id] != '0);
  assign o_wr_addr   = fill_q[i_in_id];
  assign o_fill_addr = fill_q[i_in_id];

  // Selected slot is the tail of the selected identifier
  assign o_tail_rd_addr = i_sel.addr;
  assign o_link_next    = i_res_addr;

  ////////////////////////////////////////
  // Pointer and counter update
  ////////////////////////////////////////

  always_comb begin
    head_d     = head_q;
    fill_d     = fill_q;
    tail_d     = tail_q;
    res_cnt_d  = res_cnt_q;
    fill_cnt_d = fill_cnt_q;
    o_link_we   = 1'b0;
    o_link_addr = '0;
    for (int i = 0; i < NumIds; i++) begin
      // Counters
      res_cnt_d[i]  = res_cnt_q[i] + cnt_t'(res_hit[i]) - cnt_t'(in_hit[i]);
      fill_cnt_d[i] = fill_cnt_q[i] + cnt_t'(in_hit[i]) - cnt_t'(sel_hit[i]);

      // Tail follows the link of the slot leaving for the output stage
      if (sel_hit[i]) begin
        tail_d[i] = i_tail_next;
      end
      // First filled entry becomes the new tail
      if (in_hit[i] && f_empty[i]) begin
        tail_d[i] = fill_q[i];
      end

      // Fill pointer steps past the slot written this cycle
      if (in_hit[i] && (fill_q[i] != head_q[i])) begin
        fill_d[i] = i_fill_next;
      end

      if (res_hit[i]) begin
        head_d[i] = i_res_addr;
        // No unfilled slot left, the new one is next to fill
        if ((res_cnt_q[i] == '0) || (in_hit[i] && (fill_q[i] == head_q[i]))) begin
          fill_d[i] = i_res_addr;
        end
        if (q_empty[i]) begin
          // Fresh queue starts at the new slot
          tail_d[i] = i_res_addr;
        end else begin
          // Chain the new slot after the current head
          o_link_we   = 1'b1;
          o_link_addr = head_q[i];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q     <= '{default: '0};
      fill_q     <= '{default: '0};
      tail_q     <= '{default: '0};
      res_cnt_q  <= '{default: '0};
      fill_cnt_q <= '{default: '0};
    end else begin
      head_q     <= head_d;
      fill_q     <= fill_d;
      tail_q     <= tail_d;
      res_cnt_q  <= res_cnt_d;
      fill_cnt_q <= fill_cnt_d;
    end
  end

endmodule

// File: rtl/next_ptr_table.sv
// Next-slot link table with one write port and two combinational read ports
`timescale 1ns/100ps

module next_ptr_table import wresp_bank_pkg::*; #(
  parameter int unsigned Capacity = wresp_bank_pkg::Capacity
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  // Link write from a reservation
  input  logic  i_wr_en,
  input  addr_t i_wr_addr,
  input  addr_t i_wr_next,
  // Link after the fill pointer
  input  addr_t i_rd_a_addr,
  output addr_t o_rd_a_next,
  // Link after the tail pointer
  input  addr_t i_rd_b_addr,
  output addr_t o_rd_b_next
);

  // Entry k names the slot reserved right after slot k for the same identifier
  addr_t links_q [Capacity];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      links_q <= '{default: '0};
    end else if (i_wr_en) begin
      links_q[i_wr_addr] <= i_wr_next;
    end
  end

  // Reads see the table as of the last edge
  assign o_rd_a_next = links_q[i_rd_a_addr];
  assign o_rd_b_next = links_q[i_rd_b_addr];

endmodule

// File: rtl/slot_allocator.sv
// Slot allocator tracking occupied slots and granting the lowest free one
`timescale 1ns/100ps

module slot_allocator import wresp_bank_pkg::*; #(
  parameter int unsigned Capacity = wresp_bank_pkg::Capacity
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Reservation takes the offered slot
  input  logic                i_alloc,
  // Slot handed back after its output handshake
  input  logic                i_free_valid,
  input  addr_t               i_free_addr,
  output addr_t               o_free_addr,
  output logic                o_any_free,
  output logic [Capacity-1:0] o_released_onehot
);

  // One bit per slot, set while reserved or holding data
  logic [Capacity-1:0] occ_d, occ_q;

  // Priority search, lowest clear bit wins
  always_comb begin
    o_free_addr = '0;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!occ_q[i]) begin
        o_free_addr = addr_t'(i);
      end
    end
  end

  assign o_any_free = ~&occ_q;

  // Freed slot in one-hot form
  assign o_released_onehot = i_free_valid ? (Capacity'(1) << i_free_addr) : '0;

  // Granted slot is free and freed slot is occupied, so both never hit the same bit
  always_comb begin
    occ_d = occ_q;
    if (i_alloc) begin
      occ_d[o_free_addr] = 1'b1;
    end
    occ_d = occ_d & ~o_released_onehot;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

// File: rtl/wresp_bank_pkg.sv
// Write-response bank package with sizes, identifier and slot types and the response word
package wresp_bank_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Number of AXI identifiers
  parameter int unsigned NumIds = 4;
  // Number of shared slots
  parameter int unsigned Capacity = 8;

  // Identifier and slot address widths
  parameter int unsigned IdWidth = 2;
  parameter int unsigned AddrWidth = 3;

  // Response payload without the identifier
  parameter int unsigned MsgWidth = 16;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [AddrWidth-1:0] addr_t;

  // One write response word
  typedef struct packed {
    id_t                 id;
    logic [MsgWidth-1:0] content;
  } wresp_t;

  // Slot selected for release, also the RAM read request
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } slot_req_t;

endpackage
